// File: source/ts_config.svh
`ifndef TS_CONFIG_SVH
`define TS_CONFIG_SVH

// task FIFO depth, power of two
`define TS_QUEUE_DEPTH 4

// line buffer address width, 512 entries
`define TS_LINE_W 9

// DRAM word address width
// layout is {page+line[8:6], line[5:0], dword, word}
`define TS_DRAM_AW 21

`endif

// File: source/ts_pkg.sv
`default_nettype none

package ts_pkg;

    // nibble slots inside a line buffer entry
    localparam int TS_PIX = 0;
    localparam int TS_PAL = 1;

    // one line buffer entry
    // renderer sees palette and pixel nibbles,
    // scanout sees one palette RAM index
    typedef union packed
    {
        logic [1:0][3:0] fields;
        logic [7:0]      idx;
    } ts_pixel_u;

endpackage

`default_nettype wire

// File: source/dram_port_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

interface dram_port_if;

    // word address of the next slot, sampled at c3
    logic [`TS_DRAM_AW-1:0] dram_addr;
    // held high while slots are wanted
    logic                   dram_req;
    // valid in the dram_next cycle
    logic [15:0]            dram_rdata;
    // c2 of a granted slot
    logic                   dram_pre_next;
    // c3 of a granted slot
    logic                   dram_next;

    modport render
    (
        output dram_addr,
        output dram_req,
        input  dram_rdata,
        input  dram_pre_next,
        input  dram_next
    );

    modport ctrl
    (
        input  dram_addr,
        input  dram_req,
        output dram_rdata,
        output dram_pre_next,
        output dram_next
    );

endinterface

`default_nettype wire

// File: source/dram_slot_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

module dram_slot_ctrl
(
    input  wire                    clk,
    input  wire                    reset,
    dram_port_if.ctrl              dram,
    output logic [`TS_DRAM_AW-1:0] mem_addr,
    output logic                   mem_rd,
    input  wire  [15:0]            mem_rdata
);

    logic [1:0]  phase;
    logic        slot;
    logic [15:0] rdata_r;

    // free-running c0..c3
    always_ff @(posedge clk)
    begin
        if (reset)
            phase <= 2'd0;
        else
            phase <= phase + 2'd1;
    end

    // request seen at c3 makes the next frame a slot
    always_ff @(posedge clk)
    begin
        if (reset)
            slot <= 1'b0;
        else if (phase == 2'd3)
            slot <= dram.dram_req;
    end

    // address latched with the grant, held for the read
    always_ff @(posedge clk)
    begin
        if (phase == 2'd3 && dram.dram_req)
            mem_addr <= dram.dram_addr;
    end

    // memory answers at c2, word held for c3
    always_ff @(posedge clk)
    begin
        if (slot && phase == 2'd2)
            rdata_r <= mem_rdata;
    end

    assign mem_rd             = slot && (phase == 2'd0);
    assign dram.dram_pre_next = slot && (phase == 2'd2);
    assign dram.dram_next     = slot && (phase == 2'd3);
    assign dram.dram_rdata    = rdata_r;

    // next strobe pairs with the pre-next of the same slot
    a_next_after_pre: assert property (@(posedge clk) disable iff (reset)
        dram.dram_next == $past(dram.dram_pre_next));

endmodule

`default_nettype wire

// File: source/ts_task_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

module ts_task_queue
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  task_wr,
    input  wire [7:0]            task_page,
    input  wire [8:0]            task_line,
    input  wire [5:0]            task_addr,
    input  wire [`TS_LINE_W-1:0] task_x,
    input  wire [2:0]            task_size,
    input  wire                  task_flip,
    input  wire [3:0]            task_pal,
    output logic                 task_full,
    input  wire                  mem_rdy,
    output logic                 tsr_go,
    output logic [7:0]           tsr_page,
    output logic [8:0]           tsr_line,
    output logic [5:0]           tsr_addr,
    output logic [`TS_LINE_W-1:0] tsr_x,
    output logic [2:0]           tsr_size,
    output logic                 tsr_flip,
    output logic [3:0]           tsr_pal,
    output logic                 empty
);

    localparam int DEPTH  = `TS_QUEUE_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int TASK_W = 8 + 9 + 6 + `TS_LINE_W + 3 + 1 + 4;

    logic [TASK_W-1:0] fifo_mem [0:DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              push;

    assign task_full = (count == DEPTH[PTR_W:0]);
    assign empty     = (count == '0);
    assign push      = task_wr && !task_full;
    // head goes out as soon as the renderer is free, popped the same cycle
    assign tsr_go    = !empty && mem_rdy;

    assign {tsr_page, tsr_line, tsr_addr, tsr_x, tsr_size, tsr_flip, tsr_pal} = fifo_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= {task_page, task_line, task_addr, task_x,
                                 task_size, task_flip, task_pal};
    end

    // pointers wrap at depth
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (tsr_go)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, tsr_go};
        end
    end

    // a write into a full queue is dropped
    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        task_wr && task_full && !tsr_go |=> count == $past(count));

endmodule

`default_nettype wire

// File: source/video_ts_render.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

// one task = (x_size+1) x 8 pixels = 2*x_size+2 DRAM words
// pixel order inside a word: [7:4], [3:0], [15:12], [11:8]
// mem_rdy comes back at c3 of the last slot, one go there keeps slots back to back
module video_ts_render
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire  [`TS_LINE_W-1:0]  x_coord,
    input  wire  [2:0]             x_size,
    input  wire                    flip,
    input  wire                    tsr_go,
    input  wire  [5:0]             addr,
    input  wire  [8:0]             line,
    input  wire  [7:0]             page,
    input  wire  [3:0]             pal,
    output logic                   mem_rdy,
    output logic [`TS_LINE_W-1:0]  ts_waddr,
    output ts_pkg::ts_pixel_u      ts_wdata,
    output logic                   ts_we,
    dram_port_if.render            dram
);

    import ts_pkg::*;

    localparam int LW = `TS_LINE_W;
    localparam int AW = `TS_DRAM_AW;

    logic [AW-1:0] addr_in;
    logic [AW-1:0] addr_next;
    logic [AW-1:0] addr_reg;
    logic [4:0]    cyc;
    logic [11:0]   data;
    logic [2:0]    cnt;
    logic          render_on;
    logic [3:0]    pix;
    logic          tsr_rld;
    logic          tsr_rld_stb;
    logic [LW-1:0] x_coord_d;
    logic [3:0]    pal_d;
    logic          flip_d;
    logic [3:0]    pal_r;
    logic          flip_r;
    logic [LW-1:0] x_next;

    // request held until the last slot is granted
    assign dram.dram_req = tsr_go || !mem_rdy;

    // word address of the task start
    assign addr_in = {page + {5'd0, line[8:6]}, line[5:0], addr, 1'b0};
    // stays within one bitmap line, low 7 bits step
    assign addr_next = {addr_reg[AW-1:7], addr_reg[6:0] + {6'd0, dram.dram_next}};
    assign dram.dram_addr = tsr_go ? addr_in : addr_next;

    always_ff @(posedge clk)
    begin
        addr_reg <= dram.dram_addr;
    end

    // slot countdown, bit 4 set means idle
    assign mem_rdy = cyc[4];

    always_ff @(posedge clk)
    begin
        if (reset)
            cyc <= 5'b10000;
        else if (tsr_go)
            cyc <= {1'b0, x_size, 1'b1};
        else if (dram.dram_pre_next)
            cyc <= cyc - 5'd1;
    end

    // keep the three nibbles used after the next cycle
    always_ff @(posedge clk)
    begin
        if (dram.dram_next)
            data <= {dram.dram_rdata[3:0], dram.dram_rdata[15:8]};
    end

    // pixel counter, 0 in the next cycle, 3 at the following c2
    assign render_on = !cnt[2];

    always_ff @(posedge clk)
    begin
        if (reset)
            cnt <= 3'b100;
        else if (dram.dram_pre_next)
            cnt <= 3'b000;
        else if (render_on)
            cnt <= cnt + 3'd1;
    end

    // pending reload of the write position
    always_ff @(posedge clk)
    begin
        if (reset)
            tsr_rld <= 1'b0;
        else if (tsr_go)
            tsr_rld <= 1'b1;
        else if (dram.dram_pre_next)
            tsr_rld <= 1'b0;
    end

    assign tsr_rld_stb = tsr_rld && dram.dram_pre_next;

    // staged task fields, previous task may still be drawing
    // flipped start is the far end of the sprite
    always_ff @(posedge clk)
    begin
        if (tsr_go)
        begin
            x_coord_d <= x_coord + (flip ? {{(LW-6){1'b0}}, x_size, 3'b111} : '0);
            pal_d     <= pal;
            flip_d    <= flip;
        end
    end

    // switched at the first pre-next of the new task
    always_ff @(posedge clk)
    begin
        if (tsr_rld_stb)
        begin
            pal_r  <= pal_d;
            flip_r <= flip_d;
        end
    end

    // down when flipped
    assign x_next = flip_r ? ts_waddr - 1'b1 : ts_waddr + 1'b1;

    always_ff @(posedge clk)
    begin
        if (tsr_rld_stb)
            ts_waddr <= x_coord_d;
        else if (render_on)
            ts_waddr <= x_next;
    end

    // first nibble straight off the bus, rest from data
    always_comb
    begin
        case (cnt[1:0])
            2'd0:    pix = dram.dram_rdata[7:4];
            2'd1:    pix = data[11:8];
            2'd2:    pix = data[7:4];
            default: pix = data[3:0];
        endcase
    end

    always_comb
    begin
        ts_wdata.fields[TS_PAL] = pal_r;
        ts_wdata.fields[TS_PIX] = pix;
    end

    // pixel 0 is transparent
    assign ts_we = render_on && (pix != 4'd0);

    a_go_when_ready: assert property (@(posedge clk) disable iff (reset)
        tsr_go |-> mem_rdy);

    // writes only in the four cycles after a slot's pre-next
    a_we_in_window: assert property (@(posedge clk) disable iff (reset)
        ts_we |-> $past(dram.dram_pre_next, 1) || $past(dram.dram_pre_next, 2)
               || $past(dram.dram_pre_next, 3) || $past(dram.dram_pre_next, 4));

endmodule

`default_nettype wire

// File: source/ts_line_buf.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

module ts_line_buf
(
    input  wire                   clk,
    input  wire                   we,
    input  wire  [`TS_LINE_W-1:0] waddr,
    input  wire  ts_pkg::ts_pixel_u wdata,
    input  wire                   rd,
    input  wire  [`TS_LINE_W-1:0] raddr,
    output logic [7:0]            rdata
);

    import ts_pkg::*;

    localparam int DEPTH = 1 << `TS_LINE_W;

    ts_pixel_u mem [0:DEPTH-1];

    // scanout takes the entry as a palette index and empties it
    // same address in both ports, the later write keeps the new pixel
    always_ff @(posedge clk)
    begin
        if (rd)
        begin
            rdata      <= mem[raddr].idx;
            mem[raddr] <= '0;
        end
        if (we)
            mem[waddr] <= wdata;
    end

    // renderer never writes an empty pixel
    a_no_zero_pixel: assert property (@(posedge clk)
        we |-> wdata.fields[TS_PIX] != 4'd0);

endmodule

`default_nettype wire

// File: source/video_ts_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

module video_ts_top
(
    input  wire                    clk,
    input  wire                    reset,
    // task input
    input  wire                    task_wr,
    input  wire  [7:0]             task_page,
    input  wire  [8:0]             task_line,
    input  wire  [5:0]             task_addr,
    input  wire  [`TS_LINE_W-1:0]  task_x,
    input  wire  [2:0]             task_size,
    input  wire                    task_flip,
    input  wire  [3:0]             task_pal,
    output logic                   task_full,
    // scanout
    input  wire                    scan_rd,
    input  wire  [`TS_LINE_W-1:0]  scan_addr,
    output logic [7:0]             scan_data,
    // external memory read port
    output logic [`TS_DRAM_AW-1:0] mem_addr,
    output logic                   mem_rd,
    input  wire  [15:0]            mem_rdata,
    output logic                   busy
);

    import ts_pkg::*;

    logic                  mem_rdy;
    logic                  tsr_go;
    logic                  empty;
    logic [7:0]            tsr_page;
    logic [8:0]            tsr_line;
    logic [5:0]            tsr_addr;
    logic [`TS_LINE_W-1:0] tsr_x;
    logic [2:0]            tsr_size;
    logic                  tsr_flip;
    logic [3:0]            tsr_pal;
    logic [`TS_LINE_W-1:0] ts_waddr;
    ts_pixel_u             ts_wdata;
    logic                  ts_we;

    dram_port_if dram_bus ();

    // last four pixels of a task land up to four cycles after busy falls
    assign busy = !empty || !mem_rdy;

    ts_task_queue task_queue_i
    (
        .clk       (clk),
        .reset     (reset),
        .task_wr   (task_wr),
        .task_page (task_page),
        .task_line (task_line),
        .task_addr (task_addr),
        .task_x    (task_x),
        .task_size (task_size),
        .task_flip (task_flip),
        .task_pal  (task_pal),
        .task_full (task_full),
        .mem_rdy   (mem_rdy),
        .tsr_go    (tsr_go),
        .tsr_page  (tsr_page),
        .tsr_line  (tsr_line),
        .tsr_addr  (tsr_addr),
        .tsr_x     (tsr_x),
        .tsr_size  (tsr_size),
        .tsr_flip  (tsr_flip),
        .tsr_pal   (tsr_pal),
        .empty     (empty)
    );

    video_ts_render render_i
    (
        .clk      (clk),
        .reset    (reset),
        .x_coord  (tsr_x),
        .x_size   (tsr_size),
        .flip     (tsr_flip),
        .tsr_go   (tsr_go),
        .addr     (tsr_addr),
        .line     (tsr_line),
        .page     (tsr_page),
        .pal      (tsr_pal),
        .mem_rdy  (mem_rdy),
        .ts_waddr (ts_waddr),
        .ts_wdata (ts_wdata),
        .ts_we    (ts_we),
        .dram     (dram_bus.render)
    );

    dram_slot_ctrl slot_ctrl_i
    (
        .clk       (clk),
        .reset     (reset),
        .dram      (dram_bus.ctrl),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_rdata (mem_rdata)
    );

    ts_line_buf line_buf_i
    (
        .clk   (clk),
        .we    (ts_we),
        .waddr (ts_waddr),
        .wdata (ts_wdata),
        .rd    (scan_rd),
        .raddr (scan_addr),
        .rdata (scan_data)
    );

endmodule

`default_nettype wire

// File: testbench/ts_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

module ts_checker
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  task_wr,
    input  wire                  task_full,
    input  wire [7:0]            task_page,
    input  wire [8:0]            task_line,
    input  wire [5:0]            task_addr,
    input  wire [`TS_LINE_W-1:0] task_x,
    input  wire [2:0]            task_size,
    input  wire                  task_flip,
    input  wire [3:0]            task_pal,
    input  wire                  busy,
    input  wire                  scan_rd,
    input  wire [`TS_LINE_W-1:0] scan_addr,
    input  wire [7:0]            scan_data,
    input  wire                  test_start,
    input  wire                  test_done,
    input  wire [127:0]          test_name,
    output int                   test_count,
    output int                   check_count,
    output int                   error_count
);

    localparam int DEPTH = 1 << `TS_LINE_W;

    logic [7:0]            model [0:DEPTH-1];
    logic                  scan_pend;
    logic [`TS_LINE_W-1:0] scan_pend_addr;
    int                    test_checks;
    int                    test_errors;

    // memory word at a DRAM address, same pattern as the tb's memory
    function automatic logic [15:0] mem_word(input logic [20:0] a);
        logic [31:0] s;
        s = 32'hb51c ^ {a, 11'h5a5};
        repeat (3)
        begin
            s = s ^ (s << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
        end
        return s[15:0];
    endfunction

    // place one task's pixels into the reference line
    task automatic apply_task(input logic [7:0] pg, input logic [8:0] ln, input logic [5:0] ad,
                              input int x, input int sz, input logic fl, input logic [3:0] pl);
        logic [20:0] wa;
        logic [15:0] w;
        logic [3:0]  nib;
        int          start;
        int          pos;
        int          p;
        // page rows of 8k words, lines of 128 words, two words per dword
        start = (pg * 8192 + ln * 128 + ad * 2) % (1 << 21);
        for (int k = 0; k < 2 * (sz + 1); k++)
        begin
            // word index wraps inside the 128-word bitmap line
            wa = 21'(start - start % 128 + (start % 128 + k) % 128);
            w  = mem_word(wa);
            for (int j = 0; j < 4; j++)
            begin
                case (j)
                    0:       nib = w[7:4];
                    1:       nib = w[3:0];
                    2:       nib = w[15:12];
                    default: nib = w[11:8];
                endcase
                p   = 4 * k + j;
                // mirrored from the far end when flipped
                pos = fl ? (x + sz * 8 + 7 - p) : (x + p);
                if (nib != 4'd0)
                    model[pos % DEPTH] = {pl, nib};
            end
        end
    endtask

    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            model[i] = 8'h00;
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        scan_pend   = 1'b0;
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            // idle at every test start
            if (test_start)
            begin
                test_checks++;
                check_count++;
                if (busy || task_full)
                begin
                    test_errors++;
                    error_count++;
                    $display("[ERROR] %0t: not idle at test start, busy %b task_full %b",
                             $time, busy, task_full);
                end
            end
            if (task_wr && !task_full)
                apply_task(task_page, task_line, task_addr, task_x, task_size,
                           task_flip, task_pal);
            // data of last cycle's read is on scan_data now
            if (scan_pend)
            begin
                test_checks++;
                check_count++;
                if (scan_data !== model[scan_pend_addr])
                begin
                    test_errors++;
                    error_count++;
                    $display("[ERROR] %0t: scan addr %03h got %02h expected %02h",
                             $time, scan_pend_addr, scan_data, model[scan_pend_addr]);
                end
                model[scan_pend_addr] = 8'h00;
            end
            scan_pend      <= scan_rd;
            scan_pend_addr <= scan_addr;
            if (test_done)
            begin
                test_count++;
                $display("test %0d %0s: %0d checks, %0d errors, %s", test_count, test_name,
                         test_checks, test_errors, (test_errors == 0) ? "pass" : "fail");
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_video_ts.sv
`timescale 1ns/100ps
`default_nettype none

`include "ts_config.svh"

module tb_video_ts;

    logic                    clk;
    logic                    reset;
    logic                    task_wr;
    logic [7:0]              task_page;
    logic [8:0]              task_line;
    logic [5:0]              task_addr;
    logic [`TS_LINE_W-1:0]   task_x;
    logic [2:0]              task_size;
    logic                    task_flip;
    logic [3:0]              task_pal;
    logic                    task_full;
    logic                    scan_rd;
    logic [`TS_LINE_W-1:0]   scan_addr;
    logic [7:0]              scan_data;
    logic [`TS_DRAM_AW-1:0]  mem_addr;
    logic                    mem_rd;
    logic [15:0]             mem_rdata;
    logic                    busy;
    logic                    rd_pend;
    logic [`TS_DRAM_AW-1:0]  rd_pend_addr;
    logic                    test_start;
    logic                    test_done;
    logic [127:0]            test_name;
    int                      test_count;
    int                      check_count;
    int                      error_count;
    int                      cycles;
    int                      cycle_limit;

    video_ts_top video_ts_top_i
    (
        .clk       (clk),
        .reset     (reset),
        .task_wr   (task_wr),
        .task_page (task_page),
        .task_line (task_line),
        .task_addr (task_addr),
        .task_x    (task_x),
        .task_size (task_size),
        .task_flip (task_flip),
        .task_pal  (task_pal),
        .task_full (task_full),
        .scan_rd   (scan_rd),
        .scan_addr (scan_addr),
        .scan_data (scan_data),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_rdata (mem_rdata),
        .busy      (busy)
    );

    ts_checker checker_i
    (
        .clk         (clk),
        .reset       (reset),
        .task_wr     (task_wr),
        .task_full   (task_full),
        .task_page   (task_page),
        .task_line   (task_line),
        .task_addr   (task_addr),
        .task_x      (task_x),
        .task_size   (task_size),
        .task_flip   (task_flip),
        .task_pal    (task_pal),
        .busy        (busy),
        .scan_rd     (scan_rd),
        .scan_addr   (scan_addr),
        .scan_data   (scan_data),
        .test_start  (test_start),
        .test_done   (test_done),
        .test_name   (test_name),
        .test_count  (test_count),
        .check_count (check_count),
        .error_count (error_count)
    );

    // memory contents, xorshift over the whole address
    function automatic logic [15:0] mem_word(input logic [20:0] a);
        logic [31:0] s;
        s = 32'hb51c ^ {a, 11'h5a5};
        repeat (3)
        begin
            s = s ^ (s << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
        end
        return s[15:0];
    endfunction

    // 8 ns period
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // read at c0, word on mem_rdata two cycles later
    always @(posedge clk)
    begin
        rd_pend      <= mem_rd;
        rd_pend_addr <= mem_addr;
        if (rd_pend)
            mem_rdata <= mem_word(rd_pend_addr);
    end

    // run limit from the number of tests
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic drive_task(input int pg, input int ln, input int ad, input int x,
                              input int sz, input int fl, input int pl);
        @(posedge clk);
        while (task_full)
            @(posedge clk);
        task_wr   <= 1'b1;
        task_page <= pg[7:0];
        task_line <= ln[8:0];
        task_addr <= ad[5:0];
        task_x    <= x[`TS_LINE_W-1:0];
        task_size <= sz[2:0];
        task_flip <= fl[0];
        task_pal  <= pl[3:0];
        @(posedge clk);
        task_wr   <= 1'b0;
    endtask

    // busy falls before the last four pixels land
    task automatic wait_idle();
        @(posedge clk);
        while (busy)
            @(posedge clk);
        repeat (6) @(posedge clk);
    endtask

    task automatic scan_range(input int first, input int last);
        for (int a = first; a <= last; a++)
        begin
            @(posedge clk);
            scan_rd   <= 1'b1;
            scan_addr <= a[`TS_LINE_W-1:0];
        end
        @(posedge clk);
        scan_rd <= 1'b0;
        @(posedge clk);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        test_start <= 1'b1;
        @(posedge clk);
        test_start <= 1'b0;
    endtask

    task automatic pulse_done();
        @(posedge clk);
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial
    begin
        int    fd;
        int    n_tests;
        int    pending;
        int    f [0:6];
        string line;
        string kind;
        reset       = 1'b1;
        task_wr     = 1'b0;
        task_page   = '0;
        task_line   = '0;
        task_addr   = '0;
        task_x      = '0;
        task_size   = '0;
        task_flip   = 1'b0;
        task_pal    = '0;
        scan_rd     = 1'b0;
        scan_addr   = '0;
        mem_rdata   = '0;
        rd_pend     = 1'b0;
        test_start  = 1'b0;
        test_done   = 1'b0;
        test_name   = '0;
        cycles      = 0;
        cycle_limit = 0;
        pending     = 0;
        n_tests     = 0;
        // first pass counts the tests
        fd = $fopen("testbench/ts_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file testbench/ts_trace.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
                if ($sscanf(line, "%s", kind) == 1 && kind == "T")
                    n_tests++;
            $fclose(fd);
            cycle_limit = 2000 * n_tests + 100;
            repeat (8) @(posedge clk);
            reset <= 1'b0;
            fd = $fopen("testbench/ts_trace.txt", "r");
            while ($fgets(line, fd) != 0)
            begin
                if ($sscanf(line, "%s", kind) != 1)
                    continue;
                if (kind == "T")
                begin
                    void'($sscanf(line, "T %s", test_name));
                    pulse_start();
                end
                else if (kind == "W")
                begin
                    void'($sscanf(line, "W %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
                    drive_task(f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    pending = 1;
                end
                else if (kind == "S")
                begin
                    void'($sscanf(line, "S %h %h", f[0], f[1]));
                    if (pending != 0)
                        wait_idle();
                    pending = 0;
                    scan_range(f[0], f[1]);
                end
                else if (kind == "E")
                    pulse_done();
            end
            $fclose(fd);
            repeat (2) @(posedge clk);
            $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
            if (error_count == 0 && check_count > 0 && test_count == n_tests)
                $display("*** TEST PASSED ***");
            else
                $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/ts_pkg.sv
source/dram_port_if.sv
source/dram_slot_ctrl.sv
source/ts_task_queue.sv
source/video_ts_render.sv
source/ts_line_buf.sv
source/video_ts_top.sv
testbench/ts_checker.sv
testbench/tb_video_ts.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_video_ts --Mdir obj_dir -o tb_video_ts
	./obj_dir/tb_video_ts > sim.log 2>&1
	cat sim.log
	@! grep -q "\*\*\* TEST FAILED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/ts_trace.txt
# T name | W page line addr x size flip pal (hex) | S first last (hex) | E end of test
# tasks of a test render before its scans, scans clear what they read
T reset_idle
S 000 1ff
E
T single
W 10 005 03 020 0 0 5
S 018 030
E
T flip3
W 22 041 0a 100 3 1 7
S 0f8 128
E
T overlap
W 10 005 03 040 1 0 2
W 31 0c0 3f 048 1 1 9
S 038 060
E
T backpressure
W 01 010 00 000 3 0 1
W 02 020 05 010 1 1 2
W 03 030 0a 030 2 0 3
W 04 1c0 0f 020 0 1 4
W 05 050 14 100 3 1 5
W 06 060 3e 0f8 1 0 6
S 000 1ff
E
T clear_on_read
W 05 1ff 11 1f8 2 0 c
S 1f0 1ff
S 000 00f
S 1f0 1ff
S 000 00f
E
